/* filelist.f */
+incdir+logic
logic/rv32i_types.sv
logic/circular_queue.sv
logic/cdb_arbiter.sv
logic/rob.sv
logic/rob_top.sv
verif/rob_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rob_tb
RTL_TOP   ?= rob_top
FILELIST  ?= filelist.f
INCDIRS   ?= $(filter +incdir+%,$(shell cat $(FILELIST)))
SRCS      ?= $(filter-out +incdir+%,$(shell cat $(FILELIST)))
RTL_SRCS  ?= $(filter logic/%,$(SRCS))
HDRS      ?= $(wildcard logic/*.svh)
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(INCDIRS) $(RTL_SRCS) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(INCDIRS) $(SRCS) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/rob_tb.sv */
`include "rob_params.svh"

module rob_tb
    import rv32i_types::*;
();

    localparam int OP_CRDY  = 0;
    localparam int OP_DISP  = 1;
    localparam int OP_DONE  = 2;
    localparam int OP_IDLE  = 3;
    localparam int OP_CHK   = 4;
    localparam int OP_DRAIN = 5;
    localparam int OP_BURST = 6;

    // one stimulus row, cnt is slots, cycles, level or groups by op
    typedef struct packed {
        logic [2:0] test;
        logic [2:0] op;
        logic [4:0] cnt;
        rob_id_t    id;
        logic [1:0] unit;
    } row_t;

    typedef struct packed {
        rob_id_t    id;
        logic [4:0] dest;
    } exp_alloc_t;

    logic               clk = 1'b0;
    logic               rst;
    dispatch_t          dispatch [`ROB_SS];
    logic               dispatch_ready;
    alloc_t             alloc [`ROB_SS];
    fu_result_t         fu_result [`NUM_FU];
    logic [`NUM_FU-1:0] fu_ready;
    logic               commit_ready;
    commit_t            commit [`ROB_SS];

    row_t        rows [$];
    exp_alloc_t  exp_alloc [$];
    // reference rob, ids in program order plus per-id contents
    rob_id_t     order [$];
    fu_result_t  pend [`NUM_FU][$];
    logic [31:0] model_pc [`ROB_DEPTH];
    logic [4:0]  model_dest [`ROB_DEPTH];
    logic [31:0] model_value [`ROB_DEPTH];
    bit          model_done [`ROB_DEPTH];
    rob_id_t     next_id;
    int          seq;
    bit          disp_pending;
    bit          cr_prev;
    bit          granted [`NUM_FU];
    int          wait_cnt [`NUM_FU];
    int          errors;
    int          checks;
    int          cycles;
    int          limit = 1000;

    rob_top rob_top_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .alloc          (alloc),
        .fu_result      (fu_result),
        .fu_ready       (fu_ready),
        .commit_ready   (commit_ready),
        .commit         (commit)
    );

    always #10 clk = ~clk;

    // run limit scales with the table length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, DUT stopped making progress", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // negedge view of the ports, inputs are steady until the next edge
    task automatic sample_outputs();
        rob_id_t    id;
        exp_alloc_t ea;
        check_true(commit[0].valid || !commit[1].valid, "commit lane 1 valid without lane 0");
        for (int s = 0; s < `ROB_SS; s++) begin
            if (commit[s].valid) begin
                check_true(cr_prev, "commit valid after an edge with commit_ready low");
                if (order.size() == 0) begin
                    check_true(1'b0, "commit with no instruction outstanding");
                end else begin
                    id = order.pop_front();
                    check_true(model_done[id],
                               $sformatf("rob id %0d committed before its result", id));
                    check_value($sformatf("commit[%0d].rob_id", s), 32'(commit[s].rob_id),
                                32'(id));
                    check_value($sformatf("commit[%0d].pc", s), commit[s].pc, model_pc[id]);
                    check_value($sformatf("commit[%0d].dest_reg", s),
                                32'(commit[s].dest_reg), 32'(model_dest[id]));
                    check_value($sformatf("commit[%0d].value", s), commit[s].value,
                                model_value[id]);
                end
            end
        end
        // reply is due exactly one cycle after acceptance
        check_true(exp_alloc.size() == 0 || alloc[0].valid, "allocation reply missing");
        for (int s = 0; s < `ROB_SS; s++) begin
            if (alloc[s].valid) begin
                if (exp_alloc.size() == 0) begin
                    check_true(1'b0, "allocation reply with no accepted dispatch");
                end else begin
                    ea = exp_alloc.pop_front();
                    check_value($sformatf("alloc[%0d].rob_id", s), 32'(alloc[s].rob_id),
                                32'(ea.id));
                    check_value($sformatf("alloc[%0d].dest_reg", s), 32'(alloc[s].dest_reg),
                                32'(ea.dest));
                end
            end
        end
        // unit handshake, a grant is taken at the coming edge
        for (int u = 0; u < `NUM_FU; u++) begin
            check_true(fu_result[u].valid || !fu_ready[u],
                       $sformatf("fu_ready[%0d] high with no result held", u));
            if (fu_result[u].valid && fu_ready[u]) begin
                granted[u]                       = 1'b1;
                model_done[fu_result[u].rob_id]  = 1'b1;
                wait_cnt[u]                      = 0;
            end else if (fu_result[u].valid) begin
                wait_cnt[u]++;
                check_true(wait_cnt[u] <= 2,
                           $sformatf("unit %0d waited more than two grant rounds", u));
            end
        end
        // group goes in at the coming edge, ids run on from the last one
        if (disp_pending && dispatch_ready) begin
            for (int s = 0; s < `ROB_SS; s++) begin
                if (dispatch[s].valid) begin
                    model_pc[next_id]   = dispatch[s].pc;
                    model_dest[next_id] = dispatch[s].dest_reg;
                    model_done[next_id] = 1'b0;
                    order.push_back(next_id);
                    ea.id   = next_id;
                    ea.dest = dispatch[s].dest_reg;
                    exp_alloc.push_back(ea);
                    next_id = rob_id_t'((next_id + 1) % `ROB_DEPTH);
                end
            end
            disp_pending = 1'b0;
        end
        cr_prev = commit_ready;
    endtask

    // granted units drop their result, idle units take the next one
    task automatic advance_units();
        for (int u = 0; u < `NUM_FU; u++) begin
            if (granted[u]) begin
                fu_result[u].valid = 1'b0;
                granted[u]         = 1'b0;
            end
            if (!fu_result[u].valid && pend[u].size() > 0) begin
                fu_result[u] = pend[u].pop_front();
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #1;
        advance_units();
    endtask

    task automatic dispatch_group(input int n);
        for (int s = 0; s < `ROB_SS; s++) begin
            dispatch[s].valid    = s < n;
            dispatch[s].dest_reg = 5'(seq % 31 + 1);
            dispatch[s].pc       = 32'h1000 + 32'(seq * 4);
            if (s < n) begin
                seq++;
            end
        end
        disp_pending = 1'b1;
        while (disp_pending) begin
            tick();
        end
        for (int s = 0; s < `ROB_SS; s++) begin
            dispatch[s].valid = 1'b0;
        end
    endtask

    task automatic queue_result(input rob_id_t id, input int unit);
        fu_result_t r;
        r.valid         = 1'b1;
        r.rob_id        = id;
        r.value         = $urandom;
        model_value[id] = r.value;
        pend[unit].push_back(r);
    endtask

    function automatic bit outstanding();
        bit busy;
        busy = order.size() != 0 || exp_alloc.size() != 0;
        for (int u = 0; u < `NUM_FU; u++) begin
            busy = busy || pend[u].size() != 0 || fu_result[u].valid;
        end
        return busy;
    endfunction

    task automatic apply_row(input row_t r);
        case (int'(r.op))
            OP_CRDY:  commit_ready = r.cnt[0];
            OP_DISP:  dispatch_group(int'(r.cnt));
            OP_DONE:  queue_result(r.id, int'(r.unit));
            OP_IDLE:  repeat (int'(r.cnt)) tick();
            OP_CHK:   check_value("dispatch_ready", 32'(dispatch_ready), 32'(r.cnt[0]));
            OP_DRAIN: while (outstanding()) tick();
            // pairs completed youngest first on rotating units
            OP_BURST: begin
                for (int g = 0; g < int'(r.cnt); g++) begin
                    dispatch_group(2);
                    queue_result(rob_id_t'(next_id - 1), g % `NUM_FU);
                    queue_result(rob_id_t'(next_id - 2), (g + 1) % `NUM_FU);
                end
            end
            default:  check_true(1'b0, "unknown table operation");
        endcase
    endtask

    function automatic void add_row(input int test, input int op, input int cnt,
                                    input int id, input int unit);
        row_t r;
        r.test = 3'(test);
        r.op   = 3'(op);
        r.cnt  = 5'(cnt);
        r.id   = rob_id_t'(id);
        r.unit = 2'(unit);
        rows.push_back(r);
    endfunction

    function automatic string test_name(input int n);
        case (n)
            0:       return "reset state";
            1:       return "allocation ids";
            2:       return "full rob back-pressure";
            3:       return "out-of-order completion";
            4:       return "three units at once";
            5:       return "commit stall";
            default: return "sustained wraps";
        endcase
    endfunction

    task automatic build_table();
        add_row(1, OP_CRDY, 1, 0, 0);
        add_row(1, OP_DISP, 2, 0, 0);
        add_row(1, OP_DISP, 1, 0, 0);
        add_row(1, OP_DISP, 2, 0, 0);
        for (int i = 0; i < 5; i++) begin
            add_row(1, OP_DONE, 0, i, i % `NUM_FU);
        end
        add_row(1, OP_DRAIN, 0, 0, 0);
        // ids 5 to 4 fill all eight entries
        for (int i = 0; i < 4; i++) begin
            add_row(2, OP_DISP, 2, 0, 0);
        end
        add_row(2, OP_CHK, 0, 0, 0);
        add_row(2, OP_IDLE, 3, 0, 0);
        add_row(2, OP_CHK, 0, 0, 0);
        add_row(2, OP_DONE, 0, 5, 0);
        add_row(2, OP_DONE, 0, 6, 1);
        add_row(2, OP_IDLE, 6, 0, 0);
        add_row(2, OP_CHK, 1, 0, 0);
        // oldest remaining is 7, finish it last
        add_row(3, OP_DONE, 0, 4, 2);
        add_row(3, OP_DONE, 0, 3, 0);
        add_row(3, OP_DONE, 0, 2, 1);
        add_row(3, OP_IDLE, 4, 0, 0);
        add_row(3, OP_DONE, 0, 1, 2);
        add_row(3, OP_DONE, 0, 0, 0);
        add_row(3, OP_DONE, 0, 7, 1);
        add_row(3, OP_DRAIN, 0, 0, 0);
        // units 0 and 1 hold three results each, unit 2 two
        // so all three contend for several rounds
        for (int i = 0; i < 4; i++) begin
            add_row(4, OP_DISP, 2, 0, 0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row(4, OP_DONE, 0, (i + 5) % `ROB_DEPTH, i % `NUM_FU);
        end
        add_row(4, OP_DRAIN, 0, 0, 0);
        add_row(5, OP_CRDY, 0, 0, 0);
        add_row(5, OP_DISP, 2, 0, 0);
        add_row(5, OP_DONE, 0, 6, 0);
        add_row(5, OP_DONE, 0, 5, 1);
        add_row(5, OP_IDLE, 6, 0, 0);
        add_row(5, OP_CRDY, 1, 0, 0);
        add_row(5, OP_DRAIN, 0, 0, 0);
        // 24 entries, three trips around the ring
        add_row(6, OP_BURST, 12, 0, 0);
        add_row(6, OP_DRAIN, 0, 0, 0);
    endtask

    initial begin
        int mark;
        int tests;
        void'($urandom(2));
        rst          = 1'b1;
        commit_ready = 1'b0;
        next_id      = '0;
        for (int s = 0; s < `ROB_SS; s++) begin
            dispatch[s] = '0;
        end
        for (int u = 0; u < `NUM_FU; u++) begin
            fu_result[u] = '0;
        end
        build_table();
        limit = rows.size() * 20;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        mark = errors;
        for (int s = 0; s < `ROB_SS; s++) begin
            check_value($sformatf("alloc[%0d].valid", s), 32'(alloc[s].valid), 0);
            check_value($sformatf("commit[%0d].valid", s), 32'(commit[s].valid), 0);
        end
        check_value("fu_ready", 32'(fu_ready), 0);
        check_value("dispatch_ready", 32'(dispatch_ready), 1);
        $display("test 0 (%s) finished with %0d errors", test_name(0), errors - mark);
        tests = 1;
        mark  = errors;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                $display("test %0d (%s) finished with %0d errors", rows[i].test,
                         test_name(int'(rows[i].test)), errors - mark);
                tests++;
                mark = errors;
            end
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* logic/rob_top.sv */
`include "rob_params.svh"

module rob_top
    import rv32i_types::*;
(
    input  logic               clk,
    input  logic               rst,
    input  dispatch_t          dispatch [`ROB_SS],
    output logic               dispatch_ready,
    output alloc_t             alloc [`ROB_SS],
    // functional unit side
    input  fu_result_t         fu_result [`NUM_FU],
    output logic [`NUM_FU-1:0] fu_ready,
    // retirement side
    input  logic               commit_ready,
    output commit_t            commit [`ROB_SS]
);

    cdb_t cdb [`ROB_SS];

    // results funnel onto the lanes first
    cdb_arbiter cdb_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .fu_result (fu_result),
        .fu_ready  (fu_ready),
        .cdb       (cdb)
    );

    rob rob_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .alloc          (alloc),
        .cdb            (cdb),
        .commit_ready   (commit_ready),
        .commit         (commit)
    );

endmodule

/* logic/rob.sv */
`include "rob_params.svh"

module rob
    import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,
    // dispatch group, slot 1 only with slot 0
    input  dispatch_t dispatch [`ROB_SS],
    output logic      dispatch_ready,
    // ids handed back one cycle after acceptance
    output alloc_t    alloc [`ROB_SS],
    // completions from the arbiter
    input  cdb_t      cdb [`ROB_SS],
    input  logic      commit_ready,
    output commit_t   commit [`ROB_SS]
);

    localparam int CNT_W   = $clog2(`ROB_SS + 1);
    localparam int COUNT_W = $clog2(`ROB_DEPTH + 1);

    logic [CNT_W-1:0]   push_cnt;
    logic [CNT_W-1:0]   pop_cnt;
    rob_entry_t         push_data [`ROB_SS];
    logic [`ROB_SS-1:0] upd_en;
    rob_id_t            upd_idx [`ROB_SS];
    rob_entry_t         upd_data [`ROB_SS];
    rob_entry_t         head_data [`ROB_SS];
    rob_id_t            head;
    rob_id_t            tail;
    logic [COUNT_W-1:0] count;
    rob_id_t            slot_id [`ROB_SS];
    logic               prefix;

    // the queue rewrites whole entries on completion
    // so dest and pc are also kept by id to rebuild them
    logic [4:0]         dest_mem [`ROB_DEPTH];
    logic [31:0]        pc_mem [`ROB_DEPTH];

    circular_queue #(
        .QUEUE_TYPE (rob_entry_t),
        .DEPTH      (`ROB_DEPTH),
        .PORTS      (`ROB_SS)
    ) queue_i (
        .clk       (clk),
        .rst       (rst),
        .push_cnt  (push_cnt),
        .push_data (push_data),
        .pop_cnt   (pop_cnt),
        .upd_en    (upd_en),
        .upd_idx   (upd_idx),
        .upd_data  (upd_data),
        .head_data (head_data),
        .head_out  (head),
        .tail_out  (tail),
        .count     (count)
    );

    // room for a full group
    assign dispatch_ready = (COUNT_W'(`ROB_DEPTH) - count) >= COUNT_W'(`ROB_SS);

    // dispatch, ids run on from the tail in slot order
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < `ROB_SS; i++) begin
            slot_id[i]            = rob_id_t'(tail + i);
            push_data[i].done     = 1'b0;
            push_data[i].dest_reg = dispatch[i].dest_reg;
            push_data[i].pc       = dispatch[i].pc;
            push_data[i].value    = '0;
            if (dispatch_ready && dispatch[i].valid) begin
                push_cnt = push_cnt + 1'b1;
            end
        end
    end

    // completion, entry marked at the edge the lane is valid
    always_comb begin
        for (int i = 0; i < `ROB_SS; i++) begin
            upd_en[i]            = cdb[i].valid;
            upd_idx[i]           = cdb[i].rob_id;
            upd_data[i].done     = 1'b1;
            upd_data[i].dest_reg = dest_mem[cdb[i].rob_id];
            upd_data[i].pc       = pc_mem[cdb[i].rob_id];
            upd_data[i].value    = cdb[i].value;
        end
    end

    // commit the done run at the head, stop at the first gap
    // count guards against stale slots past the tail
    always_comb begin
        pop_cnt = '0;
        prefix  = commit_ready;
        for (int i = 0; i < `ROB_SS; i++) begin
            if (prefix && head_data[i].done && i < count) begin
                pop_cnt = pop_cnt + 1'b1;
            end else begin
                prefix = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_SS; i++) begin
            if (dispatch_ready && dispatch[i].valid) begin
                dest_mem[slot_id[i]] <= dispatch[i].dest_reg;
                pc_mem[slot_id[i]]   <= dispatch[i].pc;
            end
        end
    end

    // registered replies toward rename and retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROB_SS; i++) begin
                alloc[i].valid  <= 1'b0;
                commit[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `ROB_SS; i++) begin
                alloc[i].valid     <= dispatch_ready && dispatch[i].valid;
                alloc[i].rob_id    <= slot_id[i];
                alloc[i].dest_reg  <= dispatch[i].dest_reg;
                commit[i].valid    <= i < pop_cnt;
                commit[i].rob_id   <= rob_id_t'(head + i);
                commit[i].dest_reg <= head_data[i].dest_reg;
                commit[i].pc       <= head_data[i].pc;
                commit[i].value    <= head_data[i].value;
            end
        end
    end

endmodule

/* logic/cdb_arbiter.sv */
`include "rob_params.svh"

module cdb_arbiter
    import rv32i_types::*;
(
    input  logic              clk,
    input  logic              rst,
    // results held until their ready bit is seen at an edge
    input  fu_result_t        fu_result [`NUM_FU],
    output logic [`NUM_FU-1:0] fu_ready,
    // registered broadcast lanes
    output cdb_t              cdb [`ROB_SS]
);

    localparam int FU_IDX_W = $clog2(`NUM_FU);

    logic [FU_IDX_W-1:0] last_q;
    logic [FU_IDX_W-1:0] last_d;
    cdb_t                lane_d [`ROB_SS];

    // search starts one past the last unit granted
    // so every waiting unit is reached within two rounds
    always_comb begin
        int unsigned n;
        int unsigned idx;
        n        = 0;
        last_d   = last_q;
        fu_ready = '0;
        for (int k = 0; k < `ROB_SS; k++) begin
            lane_d[k] = '0;
        end
        for (int k = 1; k <= `NUM_FU; k++) begin
            idx = (last_q + k) % `NUM_FU;
            if (fu_result[idx].valid && n < `ROB_SS) begin
                fu_ready[idx]    = 1'b1;
                lane_d[n].valid  = 1'b1;
                lane_d[n].rob_id = fu_result[idx].rob_id;
                lane_d[n].value  = fu_result[idx].value;
                last_d           = FU_IDX_W'(idx);
                n                = n + 1;
            end
        end
    end

    // grant taken at the edge, lane valid the cycle after
    always_ff @(posedge clk) begin
        if (rst) begin
            last_q <= FU_IDX_W'(`NUM_FU - 1);
            for (int k = 0; k < `ROB_SS; k++) begin
                cdb[k].valid <= 1'b0;
            end
        end else begin
            last_q <= last_d;
            for (int k = 0; k < `ROB_SS; k++) begin
                cdb[k] <= lane_d[k];
            end
        end
    end

endmodule

/* logic/circular_queue.sv */
module circular_queue #(
    parameter type QUEUE_TYPE = logic,
    parameter int  DEPTH      = 8,
    parameter int  PORTS      = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    // entries written at the tail, slot 0 first
    input  logic [$clog2(PORTS+1)-1:0]   push_cnt,
    input  QUEUE_TYPE                    push_data [PORTS],
    // entries dropped from the head
    input  logic [$clog2(PORTS+1)-1:0]   pop_cnt,
    // random access rewrite of live entries
    input  logic [PORTS-1:0]             upd_en,
    input  logic [$clog2(DEPTH)-1:0]     upd_idx [PORTS],
    input  QUEUE_TYPE                    upd_data [PORTS],
    // oldest entries, head first
    output QUEUE_TYPE                    head_data [PORTS],
    output logic [$clog2(DEPTH)-1:0]     head_out,
    output logic [$clog2(DEPTH)-1:0]     tail_out,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int IDX_W   = $clog2(DEPTH);
    localparam int COUNT_W = $clog2(DEPTH + 1);

    QUEUE_TYPE          mem [DEPTH];
    logic [IDX_W-1:0]   head_q;
    logic [IDX_W-1:0]   tail_q;
    logic [COUNT_W-1:0] count_q;

    // pointer advance with wrap, works for any depth
    function automatic logic [IDX_W-1:0] wrap(input logic [IDX_W-1:0] base,
                                              input int unsigned step);
        int unsigned sum;
        sum = base + step;
        return IDX_W'(sum % DEPTH);
    endfunction

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= wrap(head_q, pop_cnt);
            tail_q  <= wrap(tail_q, push_cnt);
            count_q <= count_q + COUNT_W'(push_cnt) - COUNT_W'(pop_cnt);
        end
    end

    // storage
    // updates only hit live entries and pushes only free ones
    // so the two never collide within a cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < PORTS; i++) begin
            if (upd_en[i]) begin
                mem[upd_idx[i]] <= upd_data[i];
            end
        end
        for (int i = 0; i < PORTS; i++) begin
            if (i < push_cnt) begin
                mem[wrap(tail_q, i)] <= push_data[i];
            end
        end
    end

    // head window, may hold stale slots beyond count
    always_comb begin
        for (int i = 0; i < PORTS; i++) begin
            head_data[i] = mem[wrap(head_q, i)];
        end
    end

    assign head_out = head_q;
    assign tail_out = tail_q;
    assign count    = count_q;

endmodule

/* logic/rv32i_types.sv */
`include "rob_params.svh"

package rv32i_types;

    // index into the reorder buffer
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // one instruction handed over by rename
    typedef struct packed {
        logic        valid;
        logic [4:0]  dest_reg;
        logic [31:0] pc;
    } dispatch_t;

    // id reply so rename can record the producer
    typedef struct packed {
        logic        valid;
        rob_id_t     rob_id;
        logic [4:0]  dest_reg;
    } alloc_t;

    // one slot of the buffer
    typedef struct packed {
        logic        done;
        logic [4:0]  dest_reg;
        logic [31:0] pc;
        logic [31:0] value;
    } rob_entry_t;

    // result held by a functional unit until granted
    typedef struct packed {
        logic        valid;
        rob_id_t     rob_id;
        logic [31:0] value;
    } fu_result_t;

    // one broadcast lane
    typedef struct packed {
        logic        valid;
        rob_id_t     rob_id;
        logic [31:0] value;
    } cdb_t;

    // retired instruction toward the register file
    typedef struct packed {
        logic        valid;
        rob_id_t     rob_id;
        logic [4:0]  dest_reg;
        logic [31:0] pc;
        logic [31:0] value;
    } commit_t;

endpackage

/* logic/rob_params.svh */
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// instructions dispatched or retired per cycle
`define ROB_SS 2

// reorder buffer entries
`define ROB_DEPTH 8

// bits of a rob index, log2 of the depth
`define ROB_ID_W 3

// functional units competing for the cdb
`define NUM_FU 3

`endif
